// ==== src/axi_pkg.sv ====
`default_nettype none

package axi_pkg;

   // the top bit of an id names the initiator that issued it
   typedef logic [3:0]  axi_id_t;
   typedef logic [15:0] axi_addr_t;
   typedef logic [7:0]  axi_len_t;

   // log2 of bytes per beat, always 2 for the 32-bit data path
   typedef logic [2:0]  axi_size_t;
   typedef logic [31:0] axi_data_t;
   typedef logic [3:0]  axi_strb_t;
   typedef logic [1:0]  axi_resp_t;

   localparam axi_resp_t resp_okay = 2'b00;

endpackage

`default_nettype wire

// ==== src/xbar_pkg.sv ====
`default_nettype none

package xbar_pkg;

   import axi_pkg::*;

   localparam int num_si      = 2;
   localparam int num_mi      = 2;
   localparam int bank_bit    = 8;
   localparam int resp_id_bit = 3;
   localparam int bank_words  = 64;

   // payload widths of the routed channels, AW and AR share one
   localparam int req_pl_w = $bits(axi_id_t) + $bits(axi_addr_t) + $bits(axi_len_t) +
                             $bits(axi_size_t);
   localparam int w_pl_w   = $bits(axi_id_t) + $bits(axi_data_t) + $bits(axi_strb_t) + 1;
   localparam int b_pl_w   = $bits(axi_id_t) + $bits(axi_resp_t);
   localparam int r_pl_w   = $bits(axi_id_t) + $bits(axi_data_t) + $bits(axi_resp_t) + 1;

   typedef enum logic [1:0] {
      bank_idle,
      bank_write,
      bank_resp,
      bank_read
   } bank_state_t;

endpackage

`default_nettype wire

// ==== src/rr_sched.sv ====
`timescale 1ns/1ns
`default_nettype none

module rr_sched #(
   parameter int n_req = 2
) (
   input  logic                     clk,
   input  logic                     rstn,
   input  logic [n_req-1:0]         req,
   output logic [$clog2(n_req)-1:0] grant,
   input  logic                     advance
);

   logic [$clog2(n_req)-1:0] last;

   // scan from just past the last winner so the nearest requester wins
   always_comb begin
      int idx;
      grant = last;
      for (int k = n_req; k >= 1; k--) begin
         idx = (int'(last) + k) % n_req;
         if (req[idx]) begin
            grant = idx[$clog2(n_req)-1:0];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         last <= '0;
      end else if (advance) begin
         last <= grant;
      end
   end

   a_grant_req: assert property (@(posedge clk) disable iff (!rstn) |req |-> req[grant]);

endmodule

`default_nettype wire

// ==== src/xbar_route.sv ====
`timescale 1ns/1ns
`default_nettype none

module xbar_route #(
   parameter int n_src     = 2,
   parameter int n_dst     = 2,
   parameter int payload_w = 8
) (
   input  logic                                clk,
   input  logic                                rstn,
   input  logic [n_src-1:0]                    src_valid,
   input  logic [n_src-1:0][$clog2(n_dst)-1:0] src_dst,
   input  logic [n_src-1:0][payload_w-1:0]     src_payload,
   output logic [n_src-1:0]                    src_ready,
   output logic [n_dst-1:0]                    dst_valid,
   output logic [n_dst-1:0][payload_w-1:0]     dst_payload,
   input  logic [n_dst-1:0]                    dst_ready,
   output logic [n_dst-1:0][$clog2(n_src)-1:0] dst_accept
);

   logic [n_dst-1:0][n_src-1:0]         req;
   logic [n_dst-1:0][$clog2(n_src)-1:0] grant;
   logic [n_dst-1:0]                    can_take;
   logic [n_dst-1:0]                    take;

   for (genvar d = 0; d < n_dst; d++) begin : g_dst
      for (genvar s = 0; s < n_src; s++) begin : g_req
         assign req[d][s] = src_valid[s] & (int'(src_dst[s]) == d);
      end

      // the output register is free when empty or draining in this cycle
      assign can_take[d]   = !dst_valid[d] | dst_ready[d];
      assign take[d]       = can_take[d] & req[d][grant[d]];
      assign dst_accept[d] = grant[d];

      rr_sched #(.n_req(n_src)) u_sched (
         .clk    (clk),
         .rstn   (rstn),
         .req    (req[d]),
         .grant  (grant[d]),
         .advance(take[d])
      );

      always_ff @(posedge clk) begin
         if (!rstn) begin
            dst_valid[d] <= 1'b0;
         end else if (take[d]) begin
            dst_valid[d] <= 1'b1;
         end else if (dst_ready[d]) begin
            dst_valid[d] <= 1'b0;
         end
      end

      always_ff @(posedge clk) begin
         if (take[d]) begin
            dst_payload[d] <= src_payload[grant[d]];
         end
      end

      a_hold: assert property (@(posedge clk) disable iff (!rstn)
         dst_valid[d] && !dst_ready[d] |=> dst_valid[d] && $stable(dst_payload[d]));
   end

   for (genvar s = 0; s < n_src; s++) begin : g_src
      assign src_ready[s] = req[src_dst[s]][s] & can_take[src_dst[s]] &
                            (int'(grant[src_dst[s]]) == s);
   end

endmodule

`default_nettype wire

// ==== src/axi_xbar.sv ====
`timescale 1ns/1ns
`default_nettype none

module axi_xbar
   import axi_pkg::*, xbar_pkg::*;
(
   input  logic                   clk,
   input  logic                   rstn,

   input  axi_id_t   [num_si-1:0] s_awid,
   input  axi_addr_t [num_si-1:0] s_awaddr,
   input  axi_len_t  [num_si-1:0] s_awlen,
   input  axi_size_t [num_si-1:0] s_awsize,
   input  logic      [num_si-1:0] s_awvalid,
   output logic      [num_si-1:0] s_awready,
   input  axi_id_t   [num_si-1:0] s_wid,
   input  axi_data_t [num_si-1:0] s_wdata,
   input  axi_strb_t [num_si-1:0] s_wstrb,
   input  logic      [num_si-1:0] s_wlast,
   input  logic      [num_si-1:0] s_wvalid,
   output logic      [num_si-1:0] s_wready,
   output axi_id_t   [num_si-1:0] s_bid,
   output axi_resp_t [num_si-1:0] s_bresp,
   output logic      [num_si-1:0] s_bvalid,
   input  logic      [num_si-1:0] s_bready,
   input  axi_id_t   [num_si-1:0] s_arid,
   input  axi_addr_t [num_si-1:0] s_araddr,
   input  axi_len_t  [num_si-1:0] s_arlen,
   input  axi_size_t [num_si-1:0] s_arsize,
   input  logic      [num_si-1:0] s_arvalid,
   output logic      [num_si-1:0] s_arready,
   output axi_id_t   [num_si-1:0] s_rid,
   output axi_data_t [num_si-1:0] s_rdata,
   output axi_resp_t [num_si-1:0] s_rresp,
   output logic      [num_si-1:0] s_rlast,
   output logic      [num_si-1:0] s_rvalid,
   input  logic      [num_si-1:0] s_rready,

   output axi_id_t   [num_mi-1:0] m_awid,
   output axi_addr_t [num_mi-1:0] m_awaddr,
   output axi_len_t  [num_mi-1:0] m_awlen,
   output axi_size_t [num_mi-1:0] m_awsize,
   output logic      [num_mi-1:0] m_awvalid,
   input  logic      [num_mi-1:0] m_awready,
   output axi_id_t   [num_mi-1:0] m_wid,
   output axi_data_t [num_mi-1:0] m_wdata,
   output axi_strb_t [num_mi-1:0] m_wstrb,
   output logic      [num_mi-1:0] m_wlast,
   output logic      [num_mi-1:0] m_wvalid,
   input  logic      [num_mi-1:0] m_wready,
   input  axi_id_t   [num_mi-1:0] m_bid,
   input  axi_resp_t [num_mi-1:0] m_bresp,
   input  logic      [num_mi-1:0] m_bvalid,
   output logic      [num_mi-1:0] m_bready,
   output axi_id_t   [num_mi-1:0] m_arid,
   output axi_addr_t [num_mi-1:0] m_araddr,
   output axi_len_t  [num_mi-1:0] m_arlen,
   output axi_size_t [num_mi-1:0] m_arsize,
   output logic      [num_mi-1:0] m_arvalid,
   input  logic      [num_mi-1:0] m_arready,
   input  axi_id_t   [num_mi-1:0] m_rid,
   input  axi_data_t [num_mi-1:0] m_rdata,
   input  axi_resp_t [num_mi-1:0] m_rresp,
   input  logic      [num_mi-1:0] m_rlast,
   input  logic      [num_mi-1:0] m_rvalid,
   output logic      [num_mi-1:0] m_rready
);

   logic [num_si-1:0][$clog2(num_mi)-1:0] aw_dst, ar_dst, w_dst;
   logic [num_mi-1:0][$clog2(num_si)-1:0] b_dst, r_dst, aw_acc, w_acc;
   logic [num_si-1:0] aw_src_valid, w_src_valid, aw_fire, w_fire, w_busy;
   logic [num_mi-1:0] lock;

   logic [num_si-1:0][req_pl_w-1:0] aw_src_pl, ar_src_pl;
   logic [num_mi-1:0][req_pl_w-1:0] aw_dst_pl, ar_dst_pl;
   logic [num_si-1:0][w_pl_w-1:0]   w_src_pl;
   logic [num_mi-1:0][w_pl_w-1:0]   w_dst_pl;
   logic [num_mi-1:0][b_pl_w-1:0]   b_src_pl;
   logic [num_si-1:0][b_pl_w-1:0]   b_dst_pl;
   logic [num_mi-1:0][r_pl_w-1:0]   r_src_pl;
   logic [num_si-1:0][r_pl_w-1:0]   r_dst_pl;

   for (genvar i = 0; i < num_si; i++) begin : g_si
      assign aw_dst[i]    = s_awaddr[i][bank_bit];
      assign ar_dst[i]    = s_araddr[i][bank_bit];
      assign aw_src_pl[i] = {s_awid[i], s_awaddr[i], s_awlen[i], s_awsize[i]};
      assign ar_src_pl[i] = {s_arid[i], s_araddr[i], s_arlen[i], s_arsize[i]};
      assign w_src_pl[i]  = {s_wid[i], s_wdata[i], s_wstrb[i], s_wlast[i]};
      assign {s_bid[i], s_bresp[i]} = b_dst_pl[i];
      assign {s_rid[i], s_rdata[i], s_rresp[i], s_rlast[i]} = r_dst_pl[i];

      // an initiator holds its next AW until its own W burst is through,
      // so w_dst stays valid for every beat of the burst
      assign aw_src_valid[i] = s_awvalid[i] & !lock[aw_dst[i]] & !w_busy[i];
      assign w_src_valid[i]  = s_wvalid[i] & w_busy[i];
      assign aw_fire[i]      = s_awvalid[i] & s_awready[i];
      assign w_fire[i]       = s_wvalid[i] & s_wready[i];

      always_ff @(posedge clk) begin
         if (!rstn) begin
            w_busy[i] <= 1'b0;
            w_dst[i]  <= '0;
         end else if (aw_fire[i]) begin
            w_busy[i] <= 1'b1;
            w_dst[i]  <= aw_dst[i];
         end else if (w_fire[i] && s_wlast[i]) begin
            w_busy[i] <= 1'b0;
         end
      end

      a_aw_id: assert property (@(posedge clk) disable iff (!rstn)
         s_awvalid[i] |-> int'(s_awid[i][resp_id_bit]) == i);
      a_ar_id: assert property (@(posedge clk) disable iff (!rstn)
         s_arvalid[i] |-> int'(s_arid[i][resp_id_bit]) == i);
   end

   for (genvar k = 0; k < num_mi; k++) begin : g_mi
      assign {m_awid[k], m_awaddr[k], m_awlen[k], m_awsize[k]} = aw_dst_pl[k];
      assign {m_arid[k], m_araddr[k], m_arlen[k], m_arsize[k]} = ar_dst_pl[k];
      assign {m_wid[k], m_wdata[k], m_wstrb[k], m_wlast[k]}    = w_dst_pl[k];
      assign b_src_pl[k] = {m_bid[k], m_bresp[k]};
      assign r_src_pl[k] = {m_rid[k], m_rdata[k], m_rresp[k], m_rlast[k]};
      assign b_dst[k]    = m_bid[k][resp_id_bit];
      assign r_dst[k]    = m_rid[k][resp_id_bit];

      // the bank is locked from its AW grant until the last W beat of that burst
      always_ff @(posedge clk) begin
         if (!rstn) begin
            lock[k] <= 1'b0;
         end else if (aw_fire[aw_acc[k]] && int'(aw_dst[aw_acc[k]]) == k) begin
            lock[k] <= 1'b1;
         end else if (w_fire[w_acc[k]] && s_wlast[w_acc[k]] && int'(w_dst[w_acc[k]]) == k) begin
            lock[k] <= 1'b0;
         end
      end
   end

   xbar_route #(.n_src(num_si), .n_dst(num_mi), .payload_w(req_pl_w)) u_aw_route (
      .clk(clk), .rstn(rstn),
      .src_valid(aw_src_valid), .src_dst(aw_dst), .src_payload(aw_src_pl),
      .src_ready(s_awready),
      .dst_valid(m_awvalid), .dst_payload(aw_dst_pl), .dst_ready(m_awready),
      .dst_accept(aw_acc)
   );

   xbar_route #(.n_src(num_si), .n_dst(num_mi), .payload_w(w_pl_w)) u_w_route (
      .clk(clk), .rstn(rstn),
      .src_valid(w_src_valid), .src_dst(w_dst), .src_payload(w_src_pl),
      .src_ready(s_wready),
      .dst_valid(m_wvalid), .dst_payload(w_dst_pl), .dst_ready(m_wready),
      .dst_accept(w_acc)
   );

   xbar_route #(.n_src(num_mi), .n_dst(num_si), .payload_w(b_pl_w)) u_b_route (
      .clk(clk), .rstn(rstn),
      .src_valid(m_bvalid), .src_dst(b_dst), .src_payload(b_src_pl),
      .src_ready(m_bready),
      .dst_valid(s_bvalid), .dst_payload(b_dst_pl), .dst_ready(s_bready),
      .dst_accept()
   );

   xbar_route #(.n_src(num_si), .n_dst(num_mi), .payload_w(req_pl_w)) u_ar_route (
      .clk(clk), .rstn(rstn),
      .src_valid(s_arvalid), .src_dst(ar_dst), .src_payload(ar_src_pl),
      .src_ready(s_arready),
      .dst_valid(m_arvalid), .dst_payload(ar_dst_pl), .dst_ready(m_arready),
      .dst_accept()
   );

   xbar_route #(.n_src(num_mi), .n_dst(num_si), .payload_w(r_pl_w)) u_r_route (
      .clk(clk), .rstn(rstn),
      .src_valid(m_rvalid), .src_dst(r_dst), .src_payload(r_src_pl),
      .src_ready(m_rready),
      .dst_valid(s_rvalid), .dst_payload(r_dst_pl), .dst_ready(s_rready),
      .dst_accept()
   );

endmodule

`default_nettype wire

// ==== src/mem_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_bank
   import axi_pkg::*, xbar_pkg::*;
(
   input  logic      clk,
   input  logic      rstn,
   input  axi_id_t   awid,
   input  axi_addr_t awaddr,
   input  axi_len_t  awlen,
   input  axi_size_t awsize,
   input  logic      awvalid,
   output logic      awready,
   input  axi_id_t   wid,
   input  axi_data_t wdata,
   input  axi_strb_t wstrb,
   input  logic      wlast,
   input  logic      wvalid,
   output logic      wready,
   output axi_id_t   bid,
   output axi_resp_t bresp,
   output logic      bvalid,
   input  logic      bready,
   input  axi_id_t   arid,
   input  axi_addr_t araddr,
   input  axi_len_t  arlen,
   input  axi_size_t arsize,
   input  logic      arvalid,
   output logic      arready,
   output axi_id_t   rid,
   output axi_data_t rdata,
   output axi_resp_t rresp,
   output logic      rlast,
   output logic      rvalid,
   input  logic      rready
);

   bank_state_t                     state;
   axi_id_t                         id_q;
   axi_len_t                        len_q;
   axi_len_t                        cnt_q;
   logic [$clog2(bank_words)-1:0]   addr_q;
   axi_data_t                       mem [bank_words] = '{default: '0};

   // writes win when both requests arrive in the same idle cycle
   assign awready = state == bank_idle;
   assign arready = (state == bank_idle) & !awvalid;
   assign wready  = state == bank_write;
   assign bvalid  = state == bank_resp;
   assign rvalid  = state == bank_read;
   assign bid     = id_q;
   assign rid     = id_q;
   assign bresp   = resp_okay;
   assign rresp   = resp_okay;
   assign rdata   = mem[addr_q];
   assign rlast   = cnt_q == len_q;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= bank_idle;
      end else begin
         case (state)
            bank_idle: begin
               if (awvalid) begin
                  state <= bank_write;
               end else if (arvalid) begin
                  state <= bank_read;
               end
            end
            bank_write: begin
               if (wvalid && wlast) begin
                  state <= bank_resp;
               end
            end
            bank_resp: begin
               if (bready) begin
                  state <= bank_idle;
               end
            end
            default: begin
               if (rready && rlast) begin
                  state <= bank_idle;
               end
            end
         endcase
      end
   end

   // word address steps by one per beat, bursts are always incrementing
   always_ff @(posedge clk) begin
      if (awvalid && awready) begin
         id_q   <= awid;
         addr_q <= awaddr[$clog2(bank_words)+1:2];
         len_q  <= awlen;
         cnt_q  <= '0;
      end else if (arvalid && arready) begin
         id_q   <= arid;
         addr_q <= araddr[$clog2(bank_words)+1:2];
         len_q  <= arlen;
         cnt_q  <= '0;
      end else if ((wvalid && wready) || (rvalid && rready)) begin
         addr_q <= addr_q + 1'b1;
         cnt_q  <= cnt_q + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      for (int b = 0; b < $bits(axi_strb_t); b++) begin
         if (wvalid && wready && wstrb[b]) begin
            mem[addr_q][8*b +: 8] <= wdata[8*b +: 8];
         end
      end
   end

   a_size: assert property (@(posedge clk) disable iff (!rstn)
      (awvalid && awready |-> awsize == 3'd2) and (arvalid && arready |-> arsize == 3'd2));

   // W beats reach the bank in burst order and belong to the accepted AW
   a_wbeat: assert property (@(posedge clk) disable iff (!rstn)
      wvalid && wready |-> wid == id_q && wlast == (cnt_q == len_q));

endmodule

`default_nettype wire

// ==== src/xbar_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module xbar_top
   import axi_pkg::*, xbar_pkg::*;
(
   input  logic                   clk,
   input  logic                   rstn,
   input  axi_id_t   [num_si-1:0] s_awid,
   input  axi_addr_t [num_si-1:0] s_awaddr,
   input  axi_len_t  [num_si-1:0] s_awlen,
   input  axi_size_t [num_si-1:0] s_awsize,
   input  logic      [num_si-1:0] s_awvalid,
   output logic      [num_si-1:0] s_awready,
   input  axi_id_t   [num_si-1:0] s_wid,
   input  axi_data_t [num_si-1:0] s_wdata,
   input  axi_strb_t [num_si-1:0] s_wstrb,
   input  logic      [num_si-1:0] s_wlast,
   input  logic      [num_si-1:0] s_wvalid,
   output logic      [num_si-1:0] s_wready,
   output axi_id_t   [num_si-1:0] s_bid,
   output axi_resp_t [num_si-1:0] s_bresp,
   output logic      [num_si-1:0] s_bvalid,
   input  logic      [num_si-1:0] s_bready,
   input  axi_id_t   [num_si-1:0] s_arid,
   input  axi_addr_t [num_si-1:0] s_araddr,
   input  axi_len_t  [num_si-1:0] s_arlen,
   input  axi_size_t [num_si-1:0] s_arsize,
   input  logic      [num_si-1:0] s_arvalid,
   output logic      [num_si-1:0] s_arready,
   output axi_id_t   [num_si-1:0] s_rid,
   output axi_data_t [num_si-1:0] s_rdata,
   output axi_resp_t [num_si-1:0] s_rresp,
   output logic      [num_si-1:0] s_rlast,
   output logic      [num_si-1:0] s_rvalid,
   input  logic      [num_si-1:0] s_rready
);

   axi_id_t   [num_mi-1:0] m_awid, m_wid, m_bid, m_arid, m_rid;
   axi_addr_t [num_mi-1:0] m_awaddr, m_araddr;
   axi_len_t  [num_mi-1:0] m_awlen, m_arlen;
   axi_size_t [num_mi-1:0] m_awsize, m_arsize;
   axi_data_t [num_mi-1:0] m_wdata, m_rdata;
   axi_strb_t [num_mi-1:0] m_wstrb;
   axi_resp_t [num_mi-1:0] m_bresp, m_rresp;
   logic      [num_mi-1:0] m_awvalid, m_awready, m_wlast, m_wvalid, m_wready;
   logic      [num_mi-1:0] m_bvalid, m_bready, m_arvalid, m_arready;
   logic      [num_mi-1:0] m_rlast, m_rvalid, m_rready;

   axi_xbar u_xbar (.*);

   for (genvar k = 0; k < num_mi; k++) begin : g_bank
      mem_bank u_bank (
         .clk(clk), .rstn(rstn),
         .awid(m_awid[k]), .awaddr(m_awaddr[k]), .awlen(m_awlen[k]), .awsize(m_awsize[k]),
         .awvalid(m_awvalid[k]), .awready(m_awready[k]),
         .wid(m_wid[k]), .wdata(m_wdata[k]), .wstrb(m_wstrb[k]), .wlast(m_wlast[k]),
         .wvalid(m_wvalid[k]), .wready(m_wready[k]),
         .bid(m_bid[k]), .bresp(m_bresp[k]), .bvalid(m_bvalid[k]), .bready(m_bready[k]),
         .arid(m_arid[k]), .araddr(m_araddr[k]), .arlen(m_arlen[k]), .arsize(m_arsize[k]),
         .arvalid(m_arvalid[k]), .arready(m_arready[k]),
         .rid(m_rid[k]), .rdata(m_rdata[k]), .rresp(m_rresp[k]), .rlast(m_rlast[k]),
         .rvalid(m_rvalid[k]), .rready(m_rready[k])
      );
   end

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
   output logic clk
);

   localparam int half_period = 10;

   initial begin
      clk = 1'b0;
      forever begin
         #half_period clk = ~clk;
      end
   end

endmodule

`default_nettype wire

// ==== verification/xbar_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module xbar_tb
   import axi_pkg::*, xbar_pkg::*;
();

   localparam int wait_limit = 200;

   logic clk;
   logic rstn = 1'b0;
   logic bp_on = 1'b0;
   axi_id_t   [num_si-1:0] s_awid, s_wid, s_bid, s_arid, s_rid;
   axi_addr_t [num_si-1:0] s_awaddr, s_araddr;
   axi_len_t  [num_si-1:0] s_awlen, s_arlen;
   axi_size_t [num_si-1:0] s_awsize, s_arsize;
   axi_data_t [num_si-1:0] s_wdata, s_rdata;
   axi_strb_t [num_si-1:0] s_wstrb;
   axi_resp_t [num_si-1:0] s_bresp, s_rresp;
   logic      [num_si-1:0] s_awvalid, s_awready, s_wlast, s_wvalid, s_wready;
   logic      [num_si-1:0] s_bvalid, s_arvalid, s_arready, s_rlast, s_rvalid;
   logic      [num_si-1:0] s_rready = '1;
   logic      [num_si-1:0] s_bready = '1;

   // expected response of the burst each initiator has open
   axi_data_t exp_rdata [num_si];
   axi_id_t   exp_rid   [num_si];
   axi_id_t   exp_bid   [num_si];
   logic      exp_rlast [num_si];
   logic      r_open    [num_si];
   logic      b_open    [num_si];
   axi_data_t ref_mem [num_mi*bank_words] = '{default: '0};
   logic [15:0] lfsr_q = 16'd40931;

   tb_clock u_clock (.clk(clk));

   xbar_top uut (.*);

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 16'hB400;
      end
      return s >> 1;
   endfunction

   // one LFSR step per bit handed out
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] bits;
      bits = '0;
      for (int k = 0; k < n; k++) begin
         bits[k] = lfsr_q[0];
         lfsr_q = lfsr_next(lfsr_q);
      end
      return bits;
   endfunction

   // initiator i owns the upper or lower half of each bank
   function automatic axi_addr_t region_addr(input int bank, input int i, input int word);
      return axi_addr_t'((bank << bank_bit) + i * (bank_words * 2) + word * 4);
   endfunction

   function automatic int word_index(input axi_addr_t addr, input int beat);
      return int'(addr[bank_bit]) * bank_words + (int'(addr[7:2]) + beat) % bank_words;
   endfunction

   function automatic axi_id_t initiator_id(input int i);
      return axi_id_t'((i << resp_id_bit) | int'(rand_bits(resp_id_bit)));
   endfunction

   function automatic logic handshake_seen(input string ch, input int i);
      case (ch)
         "aw": return s_awready[i];
         "w": return s_wready[i];
         "ar": return s_arready[i];
         "b": return s_bvalid[i] & s_bready[i];
         default: return s_rvalid[i] & s_rready[i];
      endcase
   endfunction

   task automatic report_error(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic report_timeout(input string ch, input int i);
      $display("Timeout: no %s transfer on initiator %0d within %0d cycles", ch, i, wait_limit);
      $display("Test failed");
      $fatal(1);
   endtask

   // look at the handshake at the falling edge, return on the edge that transfers
   task automatic wait_transfer(input string ch, input int i);
      int cnt;
      cnt = 0;
      @(negedge clk);
      while (!handshake_seen(ch, i)) begin
         cnt++;
         if (cnt > wait_limit) begin
            report_timeout(ch, i);
         end
         @(negedge clk);
      end
      @(posedge clk);
   endtask

   task automatic write_burst(input int i, input axi_addr_t addr, input int len,
                              input axi_id_t id, input logic gaps);
      int idx;
      axi_data_t data;
      axi_strb_t strb;
      @(posedge clk);
      s_awid[i]    <= id;
      s_awaddr[i]  <= addr;
      s_awlen[i]   <= axi_len_t'(len);
      s_awsize[i]  <= 3'd2;
      s_awvalid[i] <= 1'b1;
      wait_transfer("aw", i);
      s_awvalid[i] <= 1'b0;
      b_open[i]    <= 1'b1;
      exp_bid[i]   <= id;
      for (int b = 0; b <= len; b++) begin
         if (gaps && rand_bits(1) != 0) begin
            s_wvalid[i] <= 1'b0;
            @(posedge clk);
         end
         data = rand_bits(32);
         strb = 4'(rand_bits(4));
         idx  = word_index(addr, b);
         for (int k = 0; k < 4; k++) begin
            if (strb[k]) begin
               ref_mem[idx][8*k +: 8] = data[8*k +: 8];
            end
         end
         s_wid[i]    <= id;
         s_wdata[i]  <= data;
         s_wstrb[i]  <= strb;
         s_wlast[i]  <= b == len;
         s_wvalid[i] <= 1'b1;
         wait_transfer("w", i);
      end
      s_wvalid[i] <= 1'b0;
      s_wlast[i]  <= 1'b0;
      wait_transfer("b", i);
      b_open[i] <= 1'b0;
   endtask

   task automatic read_burst(input int i, input axi_addr_t addr, input int len,
                             input axi_id_t id);
      @(posedge clk);
      s_arid[i]    <= id;
      s_araddr[i]  <= addr;
      s_arlen[i]   <= axi_len_t'(len);
      s_arsize[i]  <= 3'd2;
      s_arvalid[i] <= 1'b1;
      r_open[i]    <= 1'b1;
      exp_rid[i]   <= id;
      wait_transfer("ar", i);
      s_arvalid[i] <= 1'b0;
      for (int b = 0; b <= len; b++) begin
         exp_rdata[i] <= ref_mem[word_index(addr, b)];
         exp_rlast[i] <= b == len;
         wait_transfer("r", i);
      end
      r_open[i] <= 1'b0;
   endtask

   task automatic mixed_traffic(input int i);
      axi_addr_t addr;
      axi_id_t   id;
      int        len;
      addr = region_addr(int'(rand_bits(1)), i, int'(rand_bits(4)));
      len  = int'(rand_bits(2));
      id   = initiator_id(i);
      write_burst(i, addr, len, id, 1'b1);
      read_burst(i, addr, len, id);
   endtask

   always @(posedge clk) begin
      if (bp_on) begin
         s_rready <= 2'(rand_bits(2));
         s_bready <= 2'(rand_bits(2));
      end else begin
         s_rready <= '1;
         s_bready <= '1;
      end
   end

   a_reset: assert property (@(posedge clk) $rose(rstn) |-> s_bvalid == '0 && s_rvalid == '0)
      else report_error("B or R valid is high right after reset");

   for (genvar i = 0; i < num_si; i++) begin : g_check
      a_r_hold: assert property (@(posedge clk) disable iff (!rstn)
         s_rvalid[i] && !s_rready[i] |=> s_rvalid[i] && $stable(s_rdata[i]) &&
         $stable(s_rid[i]) && $stable(s_rresp[i]) && $stable(s_rlast[i]))
         else report_error("R beat dropped or changed before rready");
      a_b_hold: assert property (@(posedge clk) disable iff (!rstn)
         s_bvalid[i] && !s_bready[i] |=> s_bvalid[i] && $stable(s_bid[i]) &&
         $stable(s_bresp[i]))
         else report_error("B response dropped or changed before bready");
      a_r_route: assert property (@(posedge clk) disable iff (!rstn)
         s_rvalid[i] |-> r_open[i] && s_rid[i] == exp_rid[i] && s_rresp[i] == resp_okay)
         else report_error("R beat with wrong ID or response, or no read open");
      a_r_data: assert property (@(posedge clk) disable iff (!rstn)
         s_rvalid[i] && s_rready[i] |-> s_rdata[i] == exp_rdata[i] &&
         s_rlast[i] == exp_rlast[i])
         else report_error("R data or rlast differs from the reference memory");
      a_b_route: assert property (@(posedge clk) disable iff (!rstn)
         s_bvalid[i] |-> b_open[i] && s_bid[i] == exp_bid[i] && s_bresp[i] == resp_okay)
         else report_error("B response with wrong ID or response, or no write open");
   end

   initial begin
      axi_addr_t addr;
      axi_id_t   id;
      s_awid    = '0;
      s_awaddr  = '0;
      s_awlen   = '0;
      s_awsize  = '0;
      s_awvalid = '0;
      s_wid     = '0;
      s_wdata   = '0;
      s_wstrb   = '0;
      s_wlast   = '0;
      s_wvalid  = '0;
      s_arid    = '0;
      s_araddr  = '0;
      s_arlen   = '0;
      s_arsize  = '0;
      s_arvalid = '0;
      for (int i = 0; i < num_si; i++) begin
         exp_rdata[i] = '0;
         exp_rid[i]   = '0;
         exp_bid[i]   = '0;
         exp_rlast[i] = 1'b0;
         r_open[i]    = 1'b0;
         b_open[i]    = 1'b0;
      end
      repeat (2) @(posedge clk);
      rstn <= 1'b1;

      // single beats with random strobes, each read back at once
      for (int bank = 0; bank < num_mi; bank++) begin
         for (int i = 0; i < num_si; i++) begin
            addr = region_addr(bank, i, int'(rand_bits(5)));
            id   = initiator_id(i);
            write_burst(i, addr, 0, id, 1'b0);
            read_burst(i, addr, 0, id);
         end
      end

      write_burst(0, region_addr(1, 0, 8), 3, initiator_id(0), 1'b0);
      read_burst(0, region_addr(1, 0, 8), 3, initiator_id(0));

      // both initiators on bank 0 at the same time
      fork
         write_burst(0, region_addr(0, 0, 20), 3, initiator_id(0), 1'b0);
         write_burst(1, region_addr(0, 1, 20), 3, initiator_id(1), 1'b0);
      join
      fork
         read_burst(0, region_addr(0, 0, 20), 3, initiator_id(0));
         read_burst(1, region_addr(0, 1, 20), 3, initiator_id(1));
      join

      // crossed writes with gaps in W valid
      fork
         write_burst(0, region_addr(1, 0, 0), 7, initiator_id(0), 1'b1);
         write_burst(1, region_addr(0, 1, 0), 7, initiator_id(1), 1'b1);
      join
      fork
         read_burst(0, region_addr(1, 0, 0), 7, initiator_id(0));
         read_burst(1, region_addr(0, 1, 0), 7, initiator_id(1));
      join

      @(posedge clk);
      bp_on <= 1'b1;
      repeat (8) begin
         fork
            mixed_traffic(0);
            mixed_traffic(1);
         join
      end
      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/axi_pkg.sv
src/xbar_pkg.sv
src/rr_sched.sv
src/xbar_route.sv
src/axi_xbar.sv
src/mem_bank.sv
src/xbar_top.sv
verification/tb_clock.sv
verification/xbar_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it; the exit status is the result

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module xbar_tb -f filelist.f -o xbar_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/xbar_sim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit 1
fi
exit 0
